/* hw/memBusPkg.sv */
package memBusPkg;

  // Bus geometry
  localparam int addrBits = 32;
  localparam int bytesPerWord = 4;

  // One data word on the processor and memory buses
  typedef logic [8*bytesPerWord-1:0] word_t;

  // Byte address
  typedef logic [addrBits-1:0] addr_t;

  // One enable per byte lane
  typedef logic [bytesPerWord-1:0] byteMask_t;

endpackage

/* hw/cacheCfgPkg.sv */
package cacheCfgPkg;

  import memBusPkg::*;

  // Block geometry
  localparam int wordsPerBlock = 4;
  localparam int offsetBits = $clog2(wordsPerBlock) + $clog2(bytesPerWord);

  // Widest tag, reached with the smallest supported set count of 4
  localparam int maxTagBits = addrBits - offsetBits - 2;

  function automatic int indexBits(int lines);
    return $clog2(lines);
  endfunction

  function automatic int tagBits(int lines);
    return addrBits - offsetBits - indexBits(lines);
  endfunction

  typedef logic [maxTagBits-1:0] tagField_t;

  // Tag entry of one way, the tag sits zero extended in the low bits
  typedef struct packed {
    logic valid;
    logic dirty;
    tagField_t tag;
  } tagEntry_t;

  typedef word_t [wordsPerBlock-1:0] block_t;

  typedef enum logic [2:0] {
    READY,
    WRITEBACK,
    LASTWRITEBACK,
    MEMREAD,
    LASTREAD,
    FLUSH
  } ctrlState_t;

endpackage

/* hw/cacheArrayIf.sv */
`timescale 1ns/10ps

interface cacheArrayIf #(
  parameter int lines = 16
);
  import cacheCfgPkg::*;

  // Set index shared by the tag and data arrays of the way
  logic [indexBits(lines)-1:0] index;

  logic tagWe;
  tagEntry_t tagWrite;
  tagEntry_t tagRead;

  logic dataWe;
  block_t dataWrite;
  block_t dataRead;

  modport ctrl (
    output index, tagWe, tagWrite, dataWe, dataWrite,
    input tagRead, dataRead
  );

  modport store (
    input index, tagWe, tagWrite, dataWe, dataWrite,
    output tagRead, dataRead
  );

endinterface

/* hw/cacheStore.sv */
`timescale 1ns/10ps

module cacheStore #(
  parameter int lines = 16,
  parameter type payload_t = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic [cacheCfgPkg::indexBits(lines)-1:0] index,
  input  logic we,
  input  payload_t writeData,
  output payload_t readData
);

  // One entry per set
  payload_t entries [lines];

  // All entries start at zero, so valid, dirty and LRU bits come up clear
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < lines; i++) begin
        entries[i] <= '0;
      end
    end else if (we) begin
      entries[index] <= writeData;
    end
  end

  // Read follows the index in the same cycle
  assign readData = entries[index];

endmodule

/* hw/dcacheController.sv */
`timescale 1ns/10ps

module dcacheController #(
  parameter int lines = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic memRead,
  input  logic memWrite,
  input  logic clean,
  input  memBusPkg::addr_t addr,
  input  memBusPkg::word_t writeData,
  input  memBusPkg::byteMask_t byteMask,
  output memBusPkg::word_t readData,
  output logic stall,
  output logic busRequest,
  output logic busWrite,
  output memBusPkg::addr_t busAddr,
  output memBusPkg::word_t busWriteData,
  input  memBusPkg::word_t busReadData,
  input  logic busReady,
  cacheArrayIf.ctrl way0,
  cacheArrayIf.ctrl way1,
  output logic [cacheCfgPkg::indexBits(lines)-1:0] lruIndex,
  output logic lruWe,
  output logic lruWrite,
  input  logic lruRead
);
  import memBusPkg::*;
  import cacheCfgPkg::*;

  localparam int idxW = indexBits(lines);
  localparam int tagW = tagBits(lines);
  localparam int wordW = $clog2(wordsPerBlock);
  localparam logic [wordW-1:0] lastBeat = wordW'(wordsPerBlock - 2);

  ctrlState_t state, nextState;
  logic [wordW-1:0] wordCnt;
  logic [idxW:0] flushCnt;
  logic flushing, flushDone;
  logic victimWay;
  block_t fillBuf;

  logic [tagW-1:0] reqTag;
  logic [idxW-1:0] reqIndex, curIndex;
  logic [wordW-1:0] reqOffset;

  logic request, hit0, hit1, hit, hitWay, hitAccess;
  logic missWay, missDirty, selWay;
  tagEntry_t missEntry, selEntry, tagWriteVal;
  block_t selBlock, hitBlock, hitMerged, fillBlock, writeBlock;
  word_t fillWord;
  logic fillDone, flushClean, dataWeAny, tagWeAny, weWay;

  function automatic word_t mergeBytes(word_t oldWord, word_t newWord, byteMask_t mask);
    word_t result;
    result = oldWord;
    for (int b = 0; b < bytesPerWord; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Address split into tag, set and word
  assign reqTag = addr[addrBits-1 -: tagW];
  assign reqIndex = addr[offsetBits +: idxW];
  assign reqOffset = addr[2 +: wordW];

  // Flush walk uses the upper counter bits as set and bit 0 as way
  assign curIndex = flushing ? flushCnt[idxW:1] : reqIndex;

  assign request = memRead || memWrite;
  assign hit0 = way0.tagRead.valid && (way0.tagRead.tag == tagField_t'(reqTag));
  assign hit1 = way1.tagRead.valid && (way1.tagRead.tag == tagField_t'(reqTag));
  assign hit = hit0 || hit1;
  assign hitWay = hit1;
  assign hitAccess = (state == READY) && request && hit && !(clean && !flushDone);

  // Victim is an invalid way first, else the LRU way
  always_comb begin
    if (!way0.tagRead.valid) begin
      missWay = 1'b0;
    end else if (!way1.tagRead.valid) begin
      missWay = 1'b1;
    end else begin
      missWay = lruRead;
    end
  end

  assign missEntry = missWay ? way1.tagRead : way0.tagRead;
  assign missDirty = missEntry.valid && missEntry.dirty;

  assign selWay = flushing ? flushCnt[0] : victimWay;
  assign selEntry = selWay ? way1.tagRead : way0.tagRead;
  assign selBlock = selWay ? way1.dataRead : way0.dataRead;
  assign hitBlock = hitWay ? way1.dataRead : way0.dataRead;

  // Write-allocate merges the store into the word as it arrives
  assign fillWord = (memWrite && wordCnt == reqOffset) ?
                    mergeBytes(busReadData, writeData, byteMask) : busReadData;

  always_comb begin
    fillBlock = fillBuf;
    fillBlock[wordCnt] = fillWord;
    hitMerged = hitBlock;
    hitMerged[reqOffset] = mergeBytes(hitBlock[reqOffset], writeData, byteMask);
  end

  always_ff @(posedge clk) begin
    if (busReady && state == MEMREAD) begin
      fillBuf[wordCnt] <= fillWord;
    end
  end

  assign fillDone = (state == LASTREAD) && busReady;
  assign flushClean = (state == LASTWRITEBACK) && busReady && flushing;
  assign dataWeAny = (hitAccess && memWrite) || fillDone;
  assign tagWeAny = dataWeAny || flushClean;
  assign weWay = (state == READY) ? hitWay : selWay;
  assign writeBlock = (state == LASTREAD) ? fillBlock : hitMerged;

  // Flushed entries stay valid with dirty cleared
  always_comb begin
    tagWriteVal.valid = 1'b1;
    if (state == LASTWRITEBACK) begin
      tagWriteVal.dirty = 1'b0;
      tagWriteVal.tag = selEntry.tag;
    end else begin
      tagWriteVal.dirty = memWrite;
      tagWriteVal.tag = tagField_t'(reqTag);
    end
  end

  assign way0.index = curIndex;
  assign way1.index = curIndex;
  assign way0.tagWe = tagWeAny && !weWay;
  assign way1.tagWe = tagWeAny && weWay;
  assign way0.tagWrite = tagWriteVal;
  assign way1.tagWrite = tagWriteVal;
  assign way0.dataWe = dataWeAny && !weWay;
  assign way1.dataWe = dataWeAny && weWay;
  assign way0.dataWrite = writeBlock;
  assign way1.dataWrite = writeBlock;

  // The way just used becomes most recent
  assign lruIndex = curIndex;
  assign lruWe = hitAccess || fillDone;
  assign lruWrite = fillDone ? !victimWay : !hitWay;

  assign readData = hitBlock[reqOffset];
  assign stall = (state != READY) || (clean && !flushDone) || (request && !hit);

  assign busRequest = (state == WRITEBACK) || (state == LASTWRITEBACK) ||
                      (state == MEMREAD) || (state == LASTREAD);
  assign busWrite = (state == WRITEBACK) || (state == LASTWRITEBACK);
  assign busAddr = {(busWrite ? selEntry.tag[tagW-1:0] : reqTag), curIndex, wordCnt, 2'b00};
  assign busWriteData = selBlock[wordCnt];

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        if (clean && !flushDone) begin
          nextState = FLUSH;
        end else if (request && !hit) begin
          nextState = missDirty ? WRITEBACK : MEMREAD;
        end
      end
      WRITEBACK: begin
        if (busReady && wordCnt == lastBeat) begin
          nextState = LASTWRITEBACK;
        end
      end
      LASTWRITEBACK: begin
        if (busReady) begin
          nextState = flushing ? FLUSH : MEMREAD;
        end
      end
      MEMREAD: begin
        if (busReady && wordCnt == lastBeat) begin
          nextState = LASTREAD;
        end
      end
      LASTREAD: begin
        if (busReady) begin
          nextState = READY;
        end
      end
      FLUSH: begin
        if (selEntry.valid && selEntry.dirty) begin
          nextState = WRITEBACK;
        end else if (&flushCnt) begin
          nextState = READY;
        end
      end
      default: nextState = READY;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= READY;
      wordCnt <= '0;
      flushCnt <= '0;
      flushing <= 1'b0;
      flushDone <= 1'b0;
      victimWay <= 1'b0;
    end else begin
      state <= nextState;
      // Four beats wrap the counter back to word 0
      if (busRequest && busReady) begin
        wordCnt <= wordCnt + 1'b1;
      end
      if (state == READY) begin
        victimWay <= missWay;
      end
      // Advance only once the current entry is clean
      if (state == FLUSH && nextState != WRITEBACK) begin
        flushCnt <= flushCnt + 1'b1;
      end
      if (state == READY && nextState == FLUSH) begin
        flushing <= 1'b1;
      end else if (state == FLUSH && nextState == READY) begin
        flushing <= 1'b0;
      end
      // Holds off a second walk until clean is released
      if (state == FLUSH && nextState == READY) begin
        flushDone <= 1'b1;
      end else if (!clean) begin
        flushDone <= 1'b0;
      end
    end
  end

endmodule

/* hw/dcacheTop.sv */
`timescale 1ns/10ps

module dcacheTop #(
  parameter int lines = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic memRead,
  input  logic memWrite,
  input  logic clean,
  input  memBusPkg::addr_t addr,
  input  memBusPkg::word_t writeData,
  input  memBusPkg::byteMask_t byteMask,
  output memBusPkg::word_t readData,
  output logic stall,
  output logic busRequest,
  output logic busWrite,
  output memBusPkg::addr_t busAddr,
  output memBusPkg::word_t busWriteData,
  input  memBusPkg::word_t busReadData,
  input  logic busReady
);
  import cacheCfgPkg::*;

  logic [indexBits(lines)-1:0] lruIndex;
  logic lruWe;
  logic lruWrite;
  logic lruRead;

  cacheArrayIf #(.lines(lines)) way0Bus ();
  cacheArrayIf #(.lines(lines)) way1Bus ();

  dcacheController #(.lines(lines)) ctrl_i (
    .clk(clk),
    .reset(reset),
    .memRead(memRead),
    .memWrite(memWrite),
    .clean(clean),
    .addr(addr),
    .writeData(writeData),
    .byteMask(byteMask),
    .readData(readData),
    .stall(stall),
    .busRequest(busRequest),
    .busWrite(busWrite),
    .busAddr(busAddr),
    .busWriteData(busWriteData),
    .busReadData(busReadData),
    .busReady(busReady),
    .way0(way0Bus.ctrl),
    .way1(way1Bus.ctrl),
    .lruIndex(lruIndex),
    .lruWe(lruWe),
    .lruWrite(lruWrite),
    .lruRead(lruRead)
  );

  // Way 0 arrays
  cacheStore #(.lines(lines), .payload_t(tagEntry_t)) tagStore0_i (
    .clk(clk), .reset(reset), .index(way0Bus.index), .we(way0Bus.tagWe),
    .writeData(way0Bus.tagWrite), .readData(way0Bus.tagRead)
  );
  cacheStore #(.lines(lines), .payload_t(block_t)) dataStore0_i (
    .clk(clk), .reset(reset), .index(way0Bus.index), .we(way0Bus.dataWe),
    .writeData(way0Bus.dataWrite), .readData(way0Bus.dataRead)
  );

  // Way 1 arrays
  cacheStore #(.lines(lines), .payload_t(tagEntry_t)) tagStore1_i (
    .clk(clk), .reset(reset), .index(way1Bus.index), .we(way1Bus.tagWe),
    .writeData(way1Bus.tagWrite), .readData(way1Bus.tagRead)
  );
  cacheStore #(.lines(lines), .payload_t(block_t)) dataStore1_i (
    .clk(clk), .reset(reset), .index(way1Bus.index), .we(way1Bus.dataWe),
    .writeData(way1Bus.dataWrite), .readData(way1Bus.dataRead)
  );

  // One bit per set naming the way to evict next
  cacheStore #(.lines(lines), .payload_t(logic)) lruStore_i (
    .clk(clk), .reset(reset), .index(lruIndex), .we(lruWe),
    .writeData(lruWrite), .readData(lruRead)
  );

endmodule

/* sim/memModel.sv */
`timescale 1ns/10ps

module memModel #(
  parameter int memWords = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic busRequest,
  input  logic busWrite,
  input  memBusPkg::addr_t busAddr,
  input  memBusPkg::word_t busWriteData,
  output memBusPkg::word_t busReadData,
  output logic busReady,
  output memBusPkg::word_t image [memWords]
);
  import memBusPkg::*;

  localparam int idxBits = $clog2(memWords);

  int delay;
  logic [idxBits-1:0] wordIdx;

  initial begin
    // Every word starts as its own word address
    for (int i = 0; i < memWords; i++) begin
      image[i] = word_t'(i);
    end
    busReady = 1'b0;
    busReadData = '0;
    delay = 0;
    forever begin
      @(posedge clk);
      #1;
      // Ready is a one-cycle pulse per word
      busReady = 1'b0;
      if (!reset && busRequest) begin
        if (delay > 0) begin
          delay--;
        end else begin
          wordIdx = busAddr[2 +: idxBits];
          if (busWrite) begin
            image[wordIdx] = busWriteData;
          end else begin
            busReadData = image[wordIdx];
          end
          busReady = 1'b1;
          // Wait of 0 to 3 cycles before the next word
          delay = $urandom % 4;
        end
      end
    end
  end

endmodule

/* sim/dcacheChecker.sv */
`timescale 1ns/10ps

module dcacheChecker #(
  parameter int memWords = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic memRead,
  input  logic memWrite,
  input  logic clean,
  input  logic stall,
  input  memBusPkg::word_t readData,
  input  memBusPkg::word_t expData,
  input  int expReadBursts,
  input  int expWriteBursts,
  input  logic busRequest,
  input  logic busWrite,
  input  logic busReady,
  input  logic memCheck,
  input  memBusPkg::word_t memImage [memWords],
  input  memBusPkg::word_t refImage [memWords],
  input  logic testEnd,
  input  int testNum,
  output int errorCount,
  output int checkCount,
  output int failedTests
);
  import memBusPkg::*;

  int beats;
  int readBursts;
  int writeBursts;
  int testErrors;
  logic wasActive;
  logic active;

  assign active = memRead || memWrite || clean;

  function automatic string testName(int n);
    case (n)
      1: return "cold read";
      2: return "byte masks";
      3: return "dirty eviction";
      4: return "lru order";
      5: return "flush";
      default: return "unknown";
    endcase
  endfunction

  task automatic checkWord(string name, word_t expected, word_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkBursts(string name, int expected, int actual);
    checkCount++;
    if (actual != expected) begin
      errorCount++;
      testErrors++;
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  // Falling edge sits halfway between input changes
  always @(negedge clk) begin
    if (reset) begin
      beats = 0;
      readBursts = 0;
      writeBursts = 0;
      testErrors = 0;
      errorCount = 0;
      checkCount = 0;
      failedTests = 0;
      wasActive = 1'b0;
    end else begin
      // Each access or flush keeps its own burst tally
      if (active && !wasActive) begin
        readBursts = 0;
        writeBursts = 0;
      end
      if (busRequest && busReady) begin
        beats++;
        if (beats == 4) begin
          beats = 0;
          if (busWrite) begin
            writeBursts++;
          end else begin
            readBursts++;
          end
        end
      end
      if (active && !stall) begin
        if (memRead) begin
          checkWord("readData", expData, readData);
        end
        checkBursts("readBursts", expReadBursts, readBursts);
        checkBursts("writeBursts", expWriteBursts, writeBursts);
      end
      if (memCheck) begin
        for (int i = 0; i < memWords; i++) begin
          checkWord($sformatf("mem[%0d]", i), refImage[i], memImage[i]);
        end
      end
      if (testEnd) begin
        if (testErrors == 0) begin
          $display("test %0d %s: ok", testNum, testName(testNum));
        end else begin
          failedTests++;
          $display("test %0d %s: %0d errors", testNum, testName(testNum), testErrors);
        end
        testErrors = 0;
      end
      wasActive = active;
    end
  end

endmodule

/* sim/dcacheBus_assert.sv */
`timescale 1ns/10ps

module dcacheBus_assert (
  input logic clk,
  input logic reset,
  input logic busRequest,
  input logic busWrite,
  input logic busReady,
  input memBusPkg::addr_t busAddr,
  input cacheCfgPkg::ctrlState_t state
);
  import cacheCfgPkg::*;

  logic [1:0] beatCnt;
  logic lastBeat;

  // Words accepted or returned so far in the current burst
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      beatCnt <= '0;
    end else if (busRequest && busReady) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // Fourth word of a burst
  assign lastBeat = busReady && (beatCnt == 2'(wordsPerBlock - 1));

  requestHeld: assert property (@(posedge clk) disable iff (reset)
    busRequest && !lastBeat |=> busRequest)
    else $error("busRequest fell before the fourth busReady");

  writeStable: assert property (@(posedge clk) disable iff (reset)
    busRequest && !lastBeat |=> $stable(busWrite))
    else $error("busWrite changed within a burst");

  addrStep: assert property (@(posedge clk) disable iff (reset)
    busRequest && busReady && !lastBeat |=> busAddr == $past(busAddr) + 32'd4)
    else $error("busAddr did not advance by 4 after busReady");

  addrHold: assert property (@(posedge clk) disable iff (reset)
    busRequest && !busReady |=> $stable(busAddr))
    else $error("busAddr moved without busReady");

  lastState: assert property (@(posedge clk) disable iff (reset)
    busRequest && lastBeat |-> (state == LASTWRITEBACK || state == LASTREAD))
    else $error("fourth busReady arrived outside a closing burst state");

endmodule

/* sim/dcacheTb.sv */
`timescale 1ns/10ps

module dcacheTb;
  import memBusPkg::*;

  localparam int lines = 16;
  localparam int memWords = 1024;
  localparam int memIdxBits = $clog2(memWords);
  localparam int clkPeriod = 100;
  localparam int numTests = 5;
  localparam int maxAccesses = 9;
  localparam int timeoutCycles = 200 * maxAccesses * numTests;

  logic clk;
  logic reset;
  logic memRead;
  logic memWrite;
  logic clean;
  addr_t addr;
  word_t writeData;
  byteMask_t byteMask;
  word_t readData;
  logic stall;
  logic busRequest;
  logic busWrite;
  addr_t busAddr;
  word_t busWriteData;
  word_t busReadData;
  logic busReady;

  word_t expData;
  int expReadBursts;
  int expWriteBursts;
  logic memCheck;
  logic testEnd;
  int testNum;
  int errorCount;
  int checkCount;
  int failedTests;
  logic verdictPrinted;

  word_t refMem [memWords];
  word_t memImage [memWords];

  dcacheTop #(.lines(lines)) dut_i (
    .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite), .clean(clean),
    .addr(addr), .writeData(writeData), .byteMask(byteMask), .readData(readData),
    .stall(stall), .busRequest(busRequest), .busWrite(busWrite), .busAddr(busAddr),
    .busWriteData(busWriteData), .busReadData(busReadData), .busReady(busReady)
  );

  memModel #(.memWords(memWords)) mem_i (
    .clk(clk), .reset(reset), .busRequest(busRequest), .busWrite(busWrite),
    .busAddr(busAddr), .busWriteData(busWriteData), .busReadData(busReadData),
    .busReady(busReady), .image(memImage)
  );

  dcacheChecker #(.memWords(memWords)) chk_i (
    .clk(clk), .reset(reset), .memRead(memRead), .memWrite(memWrite), .clean(clean),
    .stall(stall), .readData(readData), .expData(expData),
    .expReadBursts(expReadBursts), .expWriteBursts(expWriteBursts),
    .busRequest(busRequest), .busWrite(busWrite), .busReady(busReady),
    .memCheck(memCheck), .memImage(memImage), .refImage(refMem),
    .testEnd(testEnd), .testNum(testNum), .errorCount(errorCount),
    .checkCount(checkCount), .failedTests(failedTests)
  );

  bind dcacheController dcacheBus_assert busAssert_i (
    .clk(clk), .reset(reset), .busRequest(busRequest), .busWrite(busWrite),
    .busReady(busReady), .busAddr(busAddr), .state(state)
  );

  function automatic word_t refRead(addr_t a);
    return refMem[a[2 +: memIdxBits]];
  endfunction

  // Processor store as seen by a flat memory
  task automatic refWrite(addr_t a, word_t data, byteMask_t mask);
    word_t merged;
    merged = refRead(a);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    refMem[a[2 +: memIdxBits]] = merged;
  endtask

  task automatic waitStallLow();
    do begin
      @(negedge clk);
    end while (stall);
  endtask

  // One processor access held until the cache accepts it
  task automatic access(logic isWrite, addr_t a, word_t data, byteMask_t mask,
                        int expR, int expW);
    @(posedge clk);
    #1;
    if (isWrite) begin
      refWrite(a, data, mask);
    end
    expData = refRead(a);
    expReadBursts = expR;
    expWriteBursts = expW;
    addr = a;
    writeData = data;
    byteMask = mask;
    memRead = !isWrite;
    memWrite = isWrite;
    waitStallLow();
    @(posedge clk);
    #1;
    memRead = 1'b0;
    memWrite = 1'b0;
  endtask

  task automatic readAt(addr_t a, int expR, int expW);
    access(1'b0, a, '0, 4'b0000, expR, expW);
  endtask

  task automatic writeAt(addr_t a, byteMask_t mask, int expR, int expW);
    access(1'b1, a, $urandom, mask, expR, expW);
  endtask

  task automatic flushCache(int expW);
    @(posedge clk);
    #1;
    expReadBursts = 0;
    expWriteBursts = expW;
    clean = 1'b1;
    waitStallLow();
    @(posedge clk);
    #1;
    clean = 1'b0;
  endtask

  task automatic compareMemory();
    @(posedge clk);
    #1;
    memCheck = 1'b1;
    @(posedge clk);
    #1;
    memCheck = 1'b0;
  endtask

  task automatic endTest(int n);
    @(posedge clk);
    #1;
    testNum = n;
    testEnd = 1'b1;
    @(posedge clk);
    #1;
    testEnd = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(timeoutCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the cache stopped responding", timeoutCycles);
    verdictPrinted = 1'b1;
    $display("tests failed");
    $finish;
  end

  // Reached only when the run halts early, such as on an assertion failure
  final begin
    if (!verdictPrinted) begin
      $display("tests failed");
    end
  end

  initial begin
    void'($urandom(32'hc73d_113b));
    reset = 1'b1;
    memRead = 1'b0;
    memWrite = 1'b0;
    clean = 1'b0;
    addr = '0;
    writeData = '0;
    byteMask = '0;
    expData = '0;
    expReadBursts = 0;
    expWriteBursts = 0;
    memCheck = 1'b0;
    testEnd = 1'b0;
    testNum = 0;
    verdictPrinted = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      refMem[i] = word_t'(i);
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Set 4, cold miss then hits
    readAt(32'h040, 1, 0);
    readAt(32'h040, 0, 0);
    readAt(32'h04C, 0, 0);
    endTest(1);

    // Write hit in set 4, write miss in set 0
    writeAt(32'h044, 4'b0011, 0, 0);
    readAt(32'h044, 0, 0);
    writeAt(32'h108, 4'b1100, 1, 0);
    readAt(32'h108, 0, 0);
    readAt(32'h10C, 0, 0);
    endTest(2);

    // X, Y, Z all in set 8
    writeAt(32'h084, 4'b1111, 1, 0);
    readAt(32'h084, 0, 0);
    writeAt(32'h188, 4'b0110, 1, 0);
    readAt(32'h188, 0, 0);
    writeAt(32'h28C, 4'b1111, 1, 1);
    readAt(32'h28C, 0, 0);
    readAt(32'h084, 1, 1);
    readAt(32'h188, 1, 1);
    endTest(3);

    // A, B, A, C in set 12 leaves A and evicts B
    readAt(32'h0C0, 1, 0);
    readAt(32'h1C4, 1, 0);
    readAt(32'h0C8, 0, 0);
    readAt(32'h2C0, 1, 0);
    readAt(32'h0C4, 0, 0);
    readAt(32'h1C0, 1, 0);
    endTest(4);

    // Sets 1, 2 and 3 join the dirty blocks of sets 0 and 4
    writeAt(32'h014, 4'b0001, 1, 0);
    writeAt(32'h028, 4'b1000, 1, 0);
    writeAt(32'h03C, 4'b1111, 1, 0);
    flushCache(5);
    compareMemory();
    readAt(32'h014, 0, 0);
    // Two new tags per set push the flushed block out, clean
    readAt(32'h114, 1, 0);
    readAt(32'h214, 1, 0);
    readAt(32'h208, 1, 0);
    readAt(32'h308, 1, 0);
    endTest(5);

    @(posedge clk);
    #1;
    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             numTests, failedTests, checkCount, errorCount);
    verdictPrinted = 1'b1;
    if (errorCount == 0 && failedTests == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hw/memBusPkg.sv
hw/cacheCfgPkg.sv
hw/cacheArrayIf.sv
hw/cacheStore.sv
hw/dcacheController.sv
hw/dcacheTop.sv
sim/memModel.sv
sim/dcacheChecker.sv
sim/dcacheBus_assert.sv
sim/dcacheTb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module dcacheTb \
  --Mdir obj_dir -o dcacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dcacheSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
